//--- logic/bignum_pkg.sv
`default_nettype none

package bignum_pkg;

    // word width seen by the structs below
    // the top level ties its register_size to this value
    localparam int word_bits = 16;

    // controller states
    typedef enum logic [2:0] {
        idle,
        loading,
        row_start,
        row_stream,
        row_wait,
        draining
    } ctrl_state_t;

    // one word product, split into halves
    typedef struct packed {
        logic [word_bits-1:0] high;
        logic [word_bits-1:0] low;
        // product of the top n word
        logic                 last;
    } partial_t;

    // one carry-resolved word of a row
    typedef struct packed {
        logic [word_bits-1:0] data;
        // set for every word of row 0
        logic                 first_row;
        // set for every word of the final row
        logic                 last_row;
        // set on the carry word that closes the row
        logic                 row_end;
    } row_word_t;

endpackage

`default_nettype wire

//--- logic/operand_ram.sv
`timescale 1ns/1ps
`default_nettype none

module operand_ram #(
    parameter int register_size = 16,
    parameter int depth = 4
) (
    input wire clk_in,
    input wire wr_en,
    input wire [((depth > 1) ? $clog2(depth) : 1)-1:0] wr_addr,
    input wire [register_size-1:0] wr_data,
    input wire [((depth > 1) ? $clog2(depth) : 1)-1:0] rd_addr,
    output logic [register_size-1:0] rd_data
);

    logic [register_size-1:0] mem [depth];

    // first read stage, the second one is rd_data itself
    logic [register_size-1:0] rd_stage;

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // two cycle read latency, address in and data out both registered
    always_ff @(posedge clk_in) begin
        rd_stage <= mem[rd_addr];
        rd_data <= rd_stage;
    end

endmodule

`default_nettype wire

//--- logic/bignum_multiplier_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bignum_multiplier_ctrl import bignum_pkg::*; #(
    parameter int register_size = 16,
    parameter int num_words = 4
) (
    input wire clk_in,
    input wire rst_in,
    input wire [register_size-1:0] n_in,
    input wire [register_size-1:0] m_in,
    input wire valid_in,
    input wire acc_ready,
    input wire product_done,
    output logic ready_out,
    output partial_t partial,
    output logic partial_valid,
    output logic row_first,
    output logic row_last
);

    localparam int addr_bits = (num_words > 1) ? $clog2(num_words) : 1;
    localparam logic [addr_bits-1:0] last_addr = addr_bits'(num_words - 1);

    // cycles in row_wait before acc_ready can be trusted again
    // covers the RAM stages, the multiply register and the shifter
    localparam logic [2:0] settle_cycles = 3'd4;

    // tag that follows each read through the RAM latency
    typedef struct packed {
        logic valid;
        logic last;
        logic first_row;
        logic last_row;
    } rd_tag_t;

    ctrl_state_t state;

    logic [addr_bits-1:0] wr_addr;
    logic [addr_bits-1:0] n_addr;
    logic [addr_bits-1:0] m_row;
    logic [2:0] settle_cnt;
    logic wr_en;

    rd_tag_t issue_tag;
    rd_tag_t tag_q1;
    rd_tag_t tag_q2;

    logic [register_size-1:0] n_word;
    logic [register_size-1:0] m_word;
    logic [2*register_size-1:0] word_product;

    // input side is open while idle or part way through a load
    assign ready_out = (state == idle) || (state == loading);
    assign wr_en = valid_in && ready_out;

    operand_ram #(
        .register_size(register_size),
        .depth(num_words)
    ) i_n_ram (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(n_in),
        .rd_addr(n_addr),
        .rd_data(n_word)
    );

    operand_ram #(
        .register_size(register_size),
        .depth(num_words)
    ) i_m_ram (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(m_in),
        .rd_addr(m_row),
        .rd_data(m_word)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= idle;
            wr_addr <= '0;
            n_addr <= '0;
            m_row <= '0;
            settle_cnt <= '0;
        end else begin
            case (state)
                idle, loading: begin
                    // gaps between strobes just hold the address
                    if (valid_in) begin
                        if (wr_addr == last_addr) begin
                            wr_addr <= '0;
                            state <= row_start;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;
                            state <= loading;
                        end
                    end
                end
                row_start: begin
                    // accumulator must have settled the previous row
                    if (acc_ready) begin
                        n_addr <= '0;
                        state <= row_stream;
                    end
                end
                row_stream: begin
                    if (n_addr == last_addr) begin
                        n_addr <= '0;
                        settle_cnt <= '0;
                        state <= row_wait;
                    end else begin
                        n_addr <= n_addr + 1'b1;
                    end
                end
                row_wait: begin
                    if (settle_cnt == settle_cycles) begin
                        settle_cnt <= '0;
                        if (m_row == last_addr) begin
                            state <= draining;
                        end else begin
                            m_row <= m_row + 1'b1;
                            state <= row_start;
                        end
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                draining: begin
                    if (product_done) begin
                        m_row <= '0;
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // the row flags ride with each read so no later block counts rows
    always_comb begin
        issue_tag.valid = (state == row_stream);
        issue_tag.last = (n_addr == last_addr);
        issue_tag.first_row = (m_row == '0);
        issue_tag.last_row = (m_row == last_addr);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tag_q1 <= '0;
            tag_q2 <= '0;
            partial_valid <= 1'b0;
            row_first <= 1'b0;
            row_last <= 1'b0;
        end else begin
            tag_q1 <= issue_tag;
            tag_q2 <= tag_q1;
            partial_valid <= tag_q2.valid;
            // flags stay stable for the whole row
            if (tag_q2.valid) begin
                row_first <= tag_q2.first_row;
                row_last <= tag_q2.last_row;
            end
        end
    end

    // tag_q2 lines up with the RAM outputs
    assign word_product = n_word * m_word;

    always_ff @(posedge clk_in) begin
        if (tag_q2.valid) begin
            partial.high <= word_product[2*register_size-1:register_size];
            partial.low <= word_product[register_size-1:0];
            partial.last <= tag_q2.last;
        end
    end

endmodule

`default_nettype wire

//--- logic/row_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module row_shifter import bignum_pkg::*; #(
    parameter int register_size = 16
) (
    input wire clk_in,
    input wire rst_in,
    input partial_t partial,
    input wire partial_valid,
    input wire row_first,
    input wire row_last,
    output row_word_t row_word,
    output logic word_valid
);

    logic [register_size-1:0] prev_high;
    logic carry;
    logic in_row;
    // final carry word is owed on the next cycle
    logic pend_final;
    logic first_q;
    logic last_q;

    logic hold_flags;
    logic first_eff;
    logic last_eff;
    logic [register_size-1:0] high_eff;
    logic carry_eff;
    logic [register_size:0] sum;

    // the first product of a row has no previous high half
    assign high_eff = in_row ? prev_high : '0;
    assign carry_eff = in_row ? carry : 1'b0;

    assign hold_flags = in_row || pend_final;
    assign first_eff = hold_flags ? first_q : row_first;
    assign last_eff = hold_flags ? last_q : row_last;

    // closing word is high plus carry, which cannot overflow
    assign sum = pend_final ?
        {1'b0, prev_high} + {{register_size{1'b0}}, carry} :
        {1'b0, partial.low} + {1'b0, high_eff} + {{register_size{1'b0}}, carry_eff};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            word_valid <= 1'b0;
            in_row <= 1'b0;
            pend_final <= 1'b0;
            carry <= 1'b0;
            first_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            word_valid <= partial_valid || pend_final;
            if (partial_valid) begin
                carry <= sum[register_size];
                in_row <= !partial.last;
                pend_final <= partial.last;
                first_q <= first_eff;
                last_q <= last_eff;
            end else if (pend_final) begin
                pend_final <= 1'b0;
                carry <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (partial_valid) begin
            prev_high <= partial.high;
        end
        row_word.data <= sum[register_size-1:0];
        row_word.first_row <= first_eff;
        row_word.last_row <= last_eff;
        row_word.row_end <= pend_final && !partial_valid;
    end

endmodule

`default_nettype wire

//--- logic/product_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module product_accumulator import bignum_pkg::*; #(
    parameter int register_size = 16,
    parameter int num_words = 4
) (
    input wire clk_in,
    input wire rst_in,
    input row_word_t row_word,
    input wire word_valid,
    output logic acc_ready,
    output logic [register_size-1:0] data_out,
    output logic valid_out,
    output logic final_out,
    output logic product_done
);

    localparam int store_words = 2 * num_words;
    localparam int idx_bits = $clog2(store_words);
    localparam logic [idx_bits-1:0] last_idx = idx_bits'(store_words - 1);

    typedef enum logic [1:0] {
        acc_idle,
        acc_add,
        acc_carry,
        acc_drain
    } acc_state_t;

    acc_state_t state;

    logic [register_size-1:0] store [store_words];
    // words holding data for the current product
    logic [store_words-1:0] live;

    logic [idx_bits-1:0] idx;
    logic [idx_bits-1:0] row_base;
    logic [idx_bits-1:0] idx_sel;
    logic carry;
    logic last_row_q;

    logic clear_live;
    logic add_en;
    logic carry_in;
    logic [register_size-1:0] cur_word;
    logic [register_size-1:0] add_word;
    logic [register_size:0] sum;

    assign acc_ready = (state == acc_idle);

    // a new row starts at its own word offset
    assign idx_sel = (state == acc_idle) ? row_base : idx;
    assign clear_live = (state == acc_idle) && word_valid && row_word.first_row;
    assign cur_word = (live[idx_sel] && !clear_live) ? store[idx_sel] : '0;

    assign add_word = (state == acc_carry) ? '0 : row_word.data;
    assign carry_in = (state == acc_idle) ? 1'b0 : carry;
    assign sum = {1'b0, cur_word} + {1'b0, add_word} + {{register_size{1'b0}}, carry_in};

    assign add_en = (word_valid && ((state == acc_idle) || (state == acc_add)))
                    || (state == acc_carry);

    always_ff @(posedge clk_in) begin
        if (add_en) begin
            store[idx_sel] <= sum[register_size-1:0];
        end
        data_out <= cur_word;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            live <= '0;
        end else if (add_en) begin
            live <= (clear_live ? '0 : live) | (store_words'(1) << idx_sel);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= acc_idle;
            idx <= '0;
            row_base <= '0;
            carry <= 1'b0;
            last_row_q <= 1'b0;
            valid_out <= 1'b0;
            final_out <= 1'b0;
            product_done <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            final_out <= 1'b0;
            product_done <= 1'b0;
            case (state)
                acc_idle: begin
                    if (word_valid) begin
                        last_row_q <= row_word.last_row;
                        carry <= sum[register_size];
                        idx <= idx_sel + 1'b1;
                        state <= acc_add;
                    end
                end
                acc_add: begin
                    if (word_valid) begin
                        carry <= sum[register_size];
                        idx <= idx + 1'b1;
                        if (row_word.row_end && sum[register_size]) begin
                            state <= acc_carry;
                        end else if (row_word.row_end) begin
                            row_base <= row_base + 1'b1;
                            state <= last_row_q ? acc_drain : acc_idle;
                            if (last_row_q) begin
                                idx <= '0;
                            end
                        end
                    end
                end
                acc_carry: begin
                    // carry ripples up one word per cycle
                    carry <= sum[register_size];
                    idx <= idx + 1'b1;
                    if (!sum[register_size]) begin
                        row_base <= row_base + 1'b1;
                        state <= last_row_q ? acc_drain : acc_idle;
                        if (last_row_q) begin
                            idx <= '0;
                        end
                    end
                end
                acc_drain: begin
                    valid_out <= 1'b1;
                    idx <= idx + 1'b1;
                    if (idx == last_idx) begin
                        final_out <= 1'b1;
                        product_done <= 1'b1;
                        idx <= '0;
                        row_base <= '0;
                        state <= acc_idle;
                    end
                end
                default: begin
                    state <= acc_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/bignum_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module bignum_multiplier import bignum_pkg::*; #(
    parameter int register_size = word_bits,
    parameter int num_words = 4
) (
    input wire clk_in,
    input wire rst_in,
    input wire [register_size-1:0] n_in,
    input wire [register_size-1:0] m_in,
    input wire valid_in,
    output logic ready_out,
    output logic [register_size-1:0] data_out,
    output logic valid_out,
    output logic final_out
);

    // the structs are sized by the package word width
    if (register_size != word_bits) begin : g_width_check
        $error("register_size must equal bignum_pkg::word_bits");
    end

    partial_t partial;
    logic partial_valid;
    logic row_first;
    logic row_last;
    row_word_t row_word;
    logic word_valid;
    logic acc_ready;
    logic product_done;

    bignum_multiplier_ctrl #(
        .register_size(register_size),
        .num_words(num_words)
    ) i_ctrl (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .n_in(n_in),
        .m_in(m_in),
        .valid_in(valid_in),
        .acc_ready(acc_ready),
        .product_done(product_done),
        .ready_out(ready_out),
        .partial(partial),
        .partial_valid(partial_valid),
        .row_first(row_first),
        .row_last(row_last)
    );

    row_shifter #(
        .register_size(register_size)
    ) i_row_shifter (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .partial(partial),
        .partial_valid(partial_valid),
        .row_first(row_first),
        .row_last(row_last),
        .row_word(row_word),
        .word_valid(word_valid)
    );

    product_accumulator #(
        .register_size(register_size),
        .num_words(num_words)
    ) i_accumulator (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .row_word(row_word),
        .word_valid(word_valid),
        .acc_ready(acc_ready),
        .data_out(data_out),
        .valid_out(valid_out),
        .final_out(final_out),
        .product_done(product_done)
    );

endmodule

`default_nettype wire

//--- verification/bignum_multiplier_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module bignum_multiplier_assertions (
    input wire clk_in,
    input wire rst_in,
    input wire ready_out,
    input wire valid_out,
    input wire final_out
);

    // number of protocol violations seen so far
    int violations = 0;

    // the last word is always a valid word
    final_has_valid: assert property (
        @(posedge clk_in) disable iff (rst_in)
        final_out |-> valid_out
    ) else begin
        violations = violations + 1;
        $error("final_out asserted without valid_out");
    end

    // output words only while the input side is closed
    no_output_while_ready: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |-> !ready_out
    ) else begin
        violations = violations + 1;
        $error("valid_out asserted while ready_out is high");
    end

    // the input side opens as soon as reset is released
    ready_after_reset: assert property (
        @(posedge clk_in)
        (!rst_in && $past(rst_in)) |-> ready_out
    ) else begin
        violations = violations + 1;
        $error("ready_out is low right after reset");
    end

endmodule

`default_nettype wire

//--- verification/bignum_multiplier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bignum_multiplier_tb;

    localparam int register_size = 16;
    localparam int num_words = 4;
    localparam int op_bits = register_size * num_words;
    localparam int clk_period = 40;
    localparam int drive_delay = 2;
    localparam int max_gap = 3;
    localparam int num_ops = 13;
    localparam int idx_w = $clog2(2 * num_words);
    localparam logic [idx_w-1:0] last_word = idx_w'(2 * num_words - 1);

    // loading with gaps, the rows, the drain and room for carry ripple
    localparam int op_cycles = num_words * (max_gap + 1) + num_words * (num_words + 6)
                               + 2 * num_words + num_words * num_words + 16;
    localparam int timeout_cycles = num_ops * op_cycles + 10;

    logic clk_in;
    logic rst_in;
    logic [register_size-1:0] n_in;
    logic [register_size-1:0] m_in;
    logic valid_in;
    logic ready_out;
    logic [register_size-1:0] data_out;
    logic valid_out;
    logic final_out;

    int seed = 32'h428f;
    logic [idx_w-1:0] out_idx;
    logic [register_size-1:0] exp_words [2 * num_words];
    logic [register_size-1:0] expected_word;

    bignum_multiplier #(
        .register_size(register_size),
        .num_words(num_words)
    ) i_bignum_multiplier (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .n_in(n_in),
        .m_in(m_in),
        .valid_in(valid_in),
        .ready_out(ready_out),
        .data_out(data_out),
        .valid_out(valid_out),
        .final_out(final_out)
    );

    bind bignum_multiplier bignum_multiplier_assertions i_assertions (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .ready_out(ready_out),
        .valid_out(valid_out),
        .final_out(final_out)
    );

    initial clk_in = 1'b0;
    always #(clk_period / 2) clk_in = ~clk_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk_in);
        #(drive_delay);
    endtask

    function automatic logic [op_bits-1:0] random_operand();
        logic [31:0] r;
        logic [op_bits-1:0] v;
        for (int k = 0; k < num_words; k++) begin
            r = $random(seed);
            v[k*register_size +: register_size] = r[register_size-1:0];
        end
        return v;
    endfunction

    // schoolbook result straight from the integer product
    function automatic logic [2*op_bits-1:0] full_product(
        input logic [op_bits-1:0] a,
        input logic [op_bits-1:0] b
    );
        return {{op_bits{1'b0}}, a} * {{op_bits{1'b0}}, b};
    endfunction

    task automatic run_product(
        input logic [op_bits-1:0] n_val,
        input logic [op_bits-1:0] m_val,
        input bit use_gaps,
        input bit stray
    );
        logic [2*op_bits-1:0] prod;
        logic [31:0] r;
        while (!ready_out) begin
            step();
        end
        prod = full_product(n_val, m_val);
        for (int i = 0; i < 2 * num_words; i++) begin
            exp_words[i] = prod[i*register_size +: register_size];
        end
        for (int i = 0; i < num_words; i++) begin
            n_in = n_val[i*register_size +: register_size];
            m_in = m_val[i*register_size +: register_size];
            valid_in = 1'b1;
            step();
            valid_in = 1'b0;
            if (use_gaps) begin
                r = $random(seed);
                // data changes during a gap must be ignored
                repeat (r[1:0]) begin
                    n_in = r[register_size-1:0];
                    m_in = ~r[register_size-1:0];
                    step();
                end
            end
        end
        while (!final_out) begin
            if (stray && !ready_out) begin
                r = $random(seed);
                valid_in = r[0];
                n_in = r[register_size-1:0];
                m_in = r[31:32-register_size];
            end
            step();
        end
        valid_in = 1'b0;
    endtask

    // position of the next output word within the product
    always @(posedge clk_in) begin
        if (rst_in) begin
            out_idx <= '0;
        end else if (valid_out) begin
            out_idx <= final_out ? '0 : out_idx + 1'b1;
        end
    end

    always_comb begin
        expected_word = exp_words[out_idx];
    end

    data_matches: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |-> data_out == expected_word
    ) else abort_run($sformatf("error at %0t: data_out = %h, expected %h",
                               $time, $sampled(data_out), $sampled(expected_word)));

    final_on_last: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (valid_out && out_idx == last_word) |-> final_out
    ) else abort_run($sformatf("error at %0t: final_out = 0, expected 1", $time));

    final_not_early: assert property (
        @(posedge clk_in) disable iff (rst_in)
        final_out |-> out_idx == last_word
    ) else abort_run($sformatf("error at %0t: final_out on word %0d, expected on word %0d",
                               $time, $sampled(out_idx), last_word));

    words_back_to_back: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (valid_out && !final_out) |=> valid_out
    ) else abort_run($sformatf("valid_out dropped before the last word of a product at %0t",
                               $time));

    // stop at the first protocol violation on the DUT ports
    always @(negedge clk_in) begin
        if (i_bignum_multiplier.i_assertions.violations != 0) begin
            abort_run("a protocol assertion on the DUT ports failed");
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        abort_run("watchdog timeout, the DUT did not finish all products in time");
    end

    initial begin
        rst_in = 1'b1;
        valid_in = 1'b0;
        n_in = '0;
        m_in = '0;
        repeat (2) @(posedge clk_in);
        #(drive_delay);
        rst_in = 1'b0;

        // longest carry chains and the trivial operands
        run_product('1, '1, 1'b0, 1'b0);
        run_product('0, random_operand(), 1'b0, 1'b1);
        run_product(random_operand(), op_bits'(1), 1'b1, 1'b0);
        run_product(op_bits'(1), '1, 1'b1, 1'b1);
        run_product('1, '0, 1'b0, 1'b1);

        for (int k = 0; k < num_ops - 5; k++) begin
            run_product(random_operand(), random_operand(), k[0], k[1]);
        end

        repeat (2) step();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bignum_multiplier.f
logic/bignum_pkg.sv
logic/operand_ram.sv
logic/bignum_multiplier_ctrl.sv
logic/row_shifter.sv
logic/product_accumulator.sv
logic/bignum_multiplier.sv
verification/bignum_multiplier_assertions.sv
verification/bignum_multiplier_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= bignum_multiplier.f
TOP ?= bignum_multiplier_tb
RTL_TOP ?= bignum_multiplier
BUILD_DIR ?= obj_dir
SIM_BIN ?= bignum_multiplier_sim
VFLAGS ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
